/* rtl/pack_pkg.sv */
`default_nettype none

package pack_pkg;

   // packed word width
   localparam int DATA_W = 21;

   // field width value, 0 up to DATA_W
   localparam int WIDTH_W = $clog2(DATA_W + 1);

   // bit fifo holds two words
   localparam int BFIFO_W = 2 * DATA_W;

   // bit fifo level, 0 up to BFIFO_W
   localparam int LEVEL_W = $clog2(BFIFO_W + 1);

   // input fifo depth is 8 words
   localparam int IN_DEPTH_LOG2 = 3;

   // output fifo depth is 4 words
   localparam int OUT_DEPTH_LOG2 = 2;

endpackage

`default_nettype wire

/* rtl/bit_fifo_if.sv */
`default_nettype none

interface bit_fifo_if;

   import pack_pkg::*;

   // push side
   logic               write;
   logic [WIDTH_W-1:0] wwidth;
   logic [DATA_W-1:0]  wdata;
   // free bits
   logic [LEVEL_W-1:0] wlevel;

   // pop side
   logic               read;
   logic [WIDTH_W-1:0] rwidth;
   logic [DATA_W-1:0]  rdata;
   // filled bits
   logic [LEVEL_W-1:0] rlevel;

   modport ctrl (
      output write, wwidth, wdata,
      input  wlevel,
      output read, rwidth,
      input  rdata, rlevel
   );

   modport fifo (
      input  write, wwidth, wdata,
      output wlevel,
      input  read, rwidth,
      output rdata, rlevel
   );

endinterface

`default_nettype wire

/* rtl/word_fifo.sv */
`default_nettype none

module word_fifo #(
   parameter int DEPTH_LOG2 = pack_pkg::IN_DEPTH_LOG2
) (
   input  wire logic                        clk_i,
   input  wire logic                        arst_n_i,
   input  wire logic                        rst_i,

   // write side
   input  wire logic                        write_i,
   input  wire logic [pack_pkg::DATA_W-1:0] wdata_i,
   output logic                             full_o,

   // read side, data one cycle after the strobe
   input  wire logic                        read_i,
   output logic      [pack_pkg::DATA_W-1:0] rdata_o,
   output logic                             empty_o
);

   import pack_pkg::*;

   logic [DATA_W-1:0]     mem [2**DEPTH_LOG2];
   logic [DEPTH_LOG2-1:0] wptr_q;
   logic [DEPTH_LOG2-1:0] rptr_q;
   logic [DEPTH_LOG2:0]   count_q;
   logic                  wr_en;
   logic                  rd_en;

   // msb of the count is only set when every slot is taken
   assign full_o  = count_q[DEPTH_LOG2];
   assign empty_o = (count_q == '0);

   // writes while full and reads while empty are ignored
   assign wr_en = write_i & ~full_o;
   assign rd_en = read_i & ~empty_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         count_q <= '0;
      end else if (rst_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         count_q <= '0;
      end else begin
         if (wr_en) begin
            wptr_q <= wptr_q + 1'b1;
         end
         if (rd_en) begin
            rptr_q <= rptr_q + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // storage
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wptr_q] <= wdata_i;
      end
   end

   // registered read port, holds until the next accepted read
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_o <= mem[rptr_q];
      end
   end

endmodule

`default_nettype wire

/* rtl/bit_fifo.sv */
`default_nettype none

module bit_fifo (
   input wire logic clk_i,
   input wire logic arst_n_i,
   input wire logic rst_i,

   bit_fifo_if.fifo bf
);

   import pack_pkg::*;

   // shift register, oldest bit at position 0
   logic [BFIFO_W-1:0] data_q;
   logic [BFIFO_W-1:0] data_d;

   // number of valid bits in data_q
   logic [LEVEL_W-1:0] fill_q;
   logic [LEVEL_W-1:0] fill_d;

   // state after the pop
   logic [BFIFO_W-1:0] popped;
   logic [LEVEL_W-1:0] fill_pop;

   // push alignment
   logic [BFIFO_W-1:0] keep_mask;
   logic [BFIFO_W-1:0] push_bits;

   // field masks for push and pop widths
   logic [DATA_W-1:0]  wmask;
   logic [DATA_W-1:0]  rmask;

   // a width of DATA_W shifts the one out and gives all ones
   assign wmask = (DATA_W'(1) << bf.wwidth) - DATA_W'(1);
   assign rmask = (DATA_W'(1) << bf.rwidth) - DATA_W'(1);

   // pop first
   always_comb begin
      if (bf.read) begin
         popped   = data_q >> bf.rwidth;
         fill_pop = fill_q - LEVEL_W'(bf.rwidth);
      end else begin
         popped   = data_q;
         fill_pop = fill_q;
      end
   end

   // then push at the reduced fill
   always_comb begin
      keep_mask = (BFIFO_W'(1) << fill_pop) - BFIFO_W'(1);
      push_bits = BFIFO_W'(bf.wdata & wmask) << fill_pop;

      // stale bits above the fill are dropped before the merge
      data_d = popped & keep_mask;
      fill_d = fill_pop;

      if (bf.write) begin
         data_d = data_d | push_bits;
         fill_d = fill_pop + LEVEL_W'(bf.wwidth);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         fill_q <= '0;
      end else if (rst_i) begin
         fill_q <= '0;
      end else begin
         fill_q <= fill_d;
      end
   end

   always_ff @(posedge clk_i) begin
      data_q <= data_d;
   end

   // head of the register, zeros above rwidth
   assign bf.rdata = data_q[DATA_W-1:0] & rmask;

   // levels
   assign bf.rlevel = fill_q;
   assign bf.wlevel = LEVEL_W'(BFIFO_W) - fill_q;

endmodule

`default_nettype wire

/* rtl/bit_pack.sv */
`default_nettype none

module bit_pack (
   input  wire logic                         clk_i,
   input  wire logic                         arst_n_i,
   input  wire logic                         rst_i,

   // configuration, only changed around rst_i
   input  wire logic                         wrap_i,
   input  wire logic [pack_pkg::WIDTH_W-1:0] width_i,

   // unpacked fields from the input fifo
   output logic                              read_o,
   input  wire logic                         rready_i,
   input  wire logic [pack_pkg::DATA_W-1:0]  rdata_i,

   // packed words to the output fifo
   output logic                              write_o,
   input  wire logic                         wready_i,
   output logic      [pack_pkg::DATA_W-1:0]  wdata_o
);

   import pack_pkg::*;

   bit_fifo_if bf_if ();

   // program counter
   logic [1:0]         pc_q;
   logic [1:0]         pc_d;

   // whole-field width of one wrapped word
   logic [WIDTH_W-1:0] wrap_acc_q;
   logic [WIDTH_W-1:0] wrap_acc_d;
   logic [WIDTH_W:0]   acc_sum;

   logic [WIDTH_W-1:0] pop_width;
   logic               read;
   logic               push;
   logic               pop;

   // one extra bit so 21 + 21 does not wrap
   assign acc_sum   = {1'b0, wrap_acc_q} + {1'b0, width_i};
   assign pop_width = wrap_i ? wrap_acc_q : WIDTH_W'(DATA_W);

   always_comb begin
      read       = 1'b0;
      push       = 1'b0;
      pop        = 1'b0;
      wrap_acc_d = wrap_acc_q;
      pc_d       = pc_q + 2'd1;

      case (pc_q)
         // size the pop, one field per cycle
         2'd0: begin
            if (wrap_i && (acc_sum <= (WIDTH_W+1)'(DATA_W))) begin
               pc_d       = pc_q;
               wrap_acc_d = acc_sum[WIDTH_W-1:0];
            end
         end
         // fetch a field if there is room for it
         2'd1: begin
            if (!rready_i || (bf_if.wlevel < LEVEL_W'(width_i))) begin
               pc_d = 2'd3;
            end else begin
               read = 1'b1;
            end
         end
         // field is on the input fifo read port now
         2'd2: begin
            push = 1'b1;
         end
         // emit a word when one is complete
         2'd3: begin
            if ((bf_if.rlevel >= LEVEL_W'(pop_width)) && wready_i) begin
               pop = 1'b1;
            end
            pc_d = 2'd1;
         end
         default: begin
            pc_d = 2'd0;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pc_q       <= 2'd0;
         wrap_acc_q <= '0;
      end else if (rst_i) begin
         pc_q       <= 2'd0;
         wrap_acc_q <= '0;
      end else begin
         pc_q       <= pc_d;
         wrap_acc_q <= wrap_acc_d;
      end
   end

   assign bf_if.write  = push;
   assign bf_if.wwidth = width_i;
   assign bf_if.wdata  = rdata_i;
   assign bf_if.read   = pop;
   assign bf_if.rwidth = pop_width;

   bit_fifo u_bit_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .rst_i   (rst_i),
      .bf      (bf_if.fifo)
   );

   assign read_o  = read;
   assign write_o = pop;
   assign wdata_o = bf_if.rdata;

endmodule

`default_nettype wire

/* rtl/bit_pack_top.sv */
`default_nettype none

module bit_pack_top (
   input  wire logic                         clk_i,
   input  wire logic                         arst_n_i,
   input  wire logic                         rst_i,
   input  wire logic                         wrap_i,
   input  wire logic [pack_pkg::WIDTH_W-1:0] width_i,

   // input word side
   input  wire logic                         in_write_i,
   input  wire logic [pack_pkg::DATA_W-1:0]  in_data_i,
   output logic                              in_full_o,

   // output word side
   input  wire logic                         out_read_i,
   output logic      [pack_pkg::DATA_W-1:0]  out_data_o,
   output logic                              out_empty_o
);

   import pack_pkg::*;

   logic              in_empty;
   logic              in_ready;
   logic [DATA_W-1:0] in_rdata;
   logic              pack_read;
   logic              pack_write;
   logic [DATA_W-1:0] pack_wdata;
   logic              out_full;
   logic              out_ready;

   assign in_ready  = ~in_empty;
   assign out_ready = ~out_full;

   word_fifo #(
      .DEPTH_LOG2(IN_DEPTH_LOG2)
   ) u_in_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .rst_i   (rst_i),
      .write_i (in_write_i),
      .wdata_i (in_data_i),
      .full_o  (in_full_o),
      .read_i  (pack_read),
      .rdata_o (in_rdata),
      .empty_o (in_empty)
   );

   bit_pack u_pack (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .rst_i   (rst_i),
      .wrap_i  (wrap_i),
      .width_i (width_i),
      .read_o  (pack_read),
      .rready_i(in_ready),
      .rdata_i (in_rdata),
      .write_o (pack_write),
      .wready_i(out_ready),
      .wdata_o (pack_wdata)
   );

   word_fifo #(
      .DEPTH_LOG2(OUT_DEPTH_LOG2)
   ) u_out_fifo (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .rst_i   (rst_i),
      .write_i (pack_write),
      .wdata_i (pack_wdata),
      .full_o  (out_full),
      .read_i  (out_read_i),
      .rdata_o (out_data_o),
      .empty_o (out_empty_o)
   );

endmodule

`default_nettype wire

/* tb/bit_pack_tb.sv */
`default_nettype none

module bit_pack_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import pack_pkg::*;

   typedef logic [DATA_W-1:0] word_t;
   typedef word_t word_q_t[$];

   // input words over all tests
   localparam int TOTAL_WORDS  = 30 + 21 + 40 + 24 + 14 + 30;
   localparam int LIMIT_CYCLES = TOTAL_WORDS * 20 + 2000;

   logic               clk;
   logic               arst_n;
   logic               rst;
   logic               wrap;
   logic [WIDTH_W-1:0] width;
   logic               in_write;
   word_t              in_data;
   logic               in_full;
   logic               out_read = 1'b0;
   word_t              out_data;
   logic               out_empty;

   word_q_t field_q;
   word_q_t exp_q;
   word_q_t got_q;
   word_t   got_word;
   logic    exp_ready;
   logic    reader_en;
   logic    read_pending = 1'b0;
   int      n_checked;
   int      total_checked;
   int      err_cnt;
   int      test_cnt;
   int      test_err_base;

   bit_pack_top UUT (
      .clk_i      (clk),
      .arst_n_i   (arst_n),
      .rst_i      (rst),
      .wrap_i     (wrap),
      .width_i    (width),
      .in_write_i (in_write),
      .in_data_i  (in_data),
      .in_full_o  (in_full),
      .out_read_i (out_read),
      .out_data_o (out_data),
      .out_empty_o(out_empty)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // low width bits of a word
   function automatic word_t field_mask(input int wd);
      return word_t'((64'd1 << wd) - 64'd1);
   endfunction

   // expected output words for a list of fields
   function automatic word_q_t pack_ref(input word_q_t fields, input int wd, input logic wr);
      word_q_t     res;
      logic [63:0] acc;
      int          nbits;
      int          per_word;
      int          k;
      acc      = '0;
      nbits    = 0;
      per_word = DATA_W / wd;
      k        = 0;
      foreach (fields[i]) begin
         if (wr) begin
            // whole fields only, upper bits stay zero
            acc = acc | (64'(fields[i] & field_mask(wd)) << (k * wd));
            k++;
            if (k == per_word) begin
               res.push_back(acc[DATA_W-1:0]);
               acc = '0;
               k   = 0;
            end
         end else begin
            // earliest bit lands at bit 0
            acc   = acc | (64'(fields[i] & field_mask(wd)) << nbits);
            nbits = nbits + wd;
            if (nbits >= DATA_W) begin
               res.push_back(acc[DATA_W-1:0]);
               acc   = acc >> DATA_W;
               nbits = nbits - DATA_W;
            end
         end
      end
      // a partial word stays in the bit fifo
      return res;
   endfunction

   // output reader, data is taken one cycle after the strobe
   always @(negedge clk) begin
      if (read_pending) begin
         got_q.push_back(out_data);
      end
      if (reader_en && !out_empty) begin
         out_read     = 1'b1;
         read_pending = 1'b1;
      end else begin
         out_read     = 1'b0;
         read_pending = 1'b0;
      end
   end

   // in-order compare against the reference
   always @(negedge clk) begin
      if (exp_ready && (got_q.size() > 0)) begin
         got_word = got_q.pop_front();
         if (n_checked >= exp_q.size()) begin
            $display("unexpected output word %h after all %0d expected words",
                     got_word, exp_q.size());
            err_cnt++;
         end else if (got_word !== exp_q[n_checked]) begin
            $display("Fail out_data_o exp %h got %h", exp_q[n_checked], got_word);
            err_cnt++;
         end
         n_checked++;
      end
   end

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         $display("Fail %s exp %h got %h", name, exp, got);
         err_cnt++;
      end
   endtask

   // new width and mode take effect through an rst_i pulse
   task automatic configure(input logic wr, input int wd);
      reader_en = 1'b0;
      exp_ready = 1'b0;
      repeat (2) @(negedge clk);
      wrap  = wr;
      width = WIDTH_W'(wd);
      rst   = 1'b1;
      @(negedge clk);
      rst = 1'b0;
      field_q.delete();
      exp_q.delete();
      got_q.delete();
      n_checked = 0;
   endtask

   task automatic drive_words(input int n);
      logic [31:0] rnd;
      int          i;
      for (i = 0; i < n; i++) begin
         while (in_full) begin
            in_write = 1'b0;
            @(negedge clk);
         end
         rnd      = $urandom;
         in_data  = rnd[DATA_W-1:0];
         in_write = 1'b1;
         field_q.push_back(rnd[DATA_W-1:0] & field_mask(int'(width)));
         @(negedge clk);
      end
      in_write = 1'b0;
   endtask

   task automatic finish_words(input int n_words);
      exp_q     = pack_ref(field_q, int'(width), wrap);
      exp_ready = 1'b1;
      while (n_checked < exp_q.size()) begin
         @(negedge clk);
      end
      // idle window, extra words would show up here
      repeat (40) @(negedge clk);
      if (n_checked != n_words) begin
         $display("Fail output word count exp %h got %h", n_words, n_checked);
         err_cnt++;
      end
      check_bit("out_empty_o", 1'b1, out_empty);
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      total_checked += n_checked;
      if (err_cnt == test_err_base) begin
         $display("test %0d %s: ok, %0d words", test_cnt, name, n_checked);
      end else begin
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
      end
      test_err_base = err_cnt;
   endtask

   initial begin
      void'($urandom(32'ha16e));
      arst_n        = 1'b0;
      rst           = 1'b0;
      wrap          = 1'b0;
      width         = WIDTH_W'(DATA_W);
      in_write      = 1'b0;
      in_data       = '0;
      exp_ready     = 1'b0;
      reader_en     = 1'b0;
      n_checked     = 0;
      total_checked = 0;
      err_cnt       = 0;
      test_cnt      = 0;
      test_err_base = 0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // idle after reset, nothing may come out
      check_bit("in_full_o", 1'b0, in_full);
      check_bit("out_empty_o", 1'b1, out_empty);
      exp_ready = 1'b1;
      reader_en = 1'b1;
      repeat (30) @(negedge clk);
      check_bit("out_empty_o", 1'b1, out_empty);
      end_test("reset values");

      configure(1'b0, 21);
      reader_en = 1'b1;
      drive_words(30);
      finish_words(30);
      end_test("stream width 21");

      configure(1'b0, 8);
      reader_en = 1'b1;
      drive_words(21);
      finish_words(8);
      end_test("stream width 8");

      configure(1'b1, 5);
      reader_en = 1'b1;
      drive_words(40);
      finish_words(10);
      end_test("wrap width 5");

      // output held back until the input fifo fills up
      configure(1'b0, 13);
      fork
         drive_words(24);
         begin
            while (!in_full) begin
               @(negedge clk);
            end
            repeat (20) @(negedge clk);
            reader_en = 1'b1;
         end
      join
      finish_words(14);
      end_test("back-pressure width 13");

      // reset in the middle of a stream, old words must vanish
      configure(1'b0, 21);
      // 4 output words, 2 in the bit fifo and 8 queued fill every fifo
      drive_words(14);
      while (!in_full) begin
         @(negedge clk);
      end
      configure(1'b1, 7);
      check_bit("out_empty_o", 1'b1, out_empty);
      check_bit("in_full_o", 1'b0, in_full);
      reader_en = 1'b1;
      drive_words(30);
      finish_words(10);
      end_test("reconfigure to wrap width 7");

      $display("tests %0d, words checked %0d, errors %0d", test_cnt, total_checked, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (LIMIT_CYCLES) @(posedge clk);
      $display("timeout, the run did not finish within %0d cycles", LIMIT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
rtl/pack_pkg.sv
rtl/bit_fifo_if.sv
rtl/word_fifo.sv
rtl/bit_fifo.sv
rtl/bit_pack.sv
rtl/bit_pack_top.sv
tb/bit_pack_tb.sv
